/* src/fetch_pkg.sv */
package fetch_pkg;

    typedef logic [31:0] pc_t;        // instruction address
    typedef logic [31:0] inst_t;      // instruction word
    typedef logic [1:0]  ibar_flag_t; // bit n set: ibar in slot n

    // gray coded, one bit flips per step
    typedef enum logic [1:0] {
        IBAR_IDLE       = 2'b00,
        IBAR_WAIT_EX    = 2'b01,
        IBAR_WAIT_CACHE = 2'b11,
        IBAR_WAIT_FETCH = 2'b10
    } ibar_state_t;

    localparam pc_t   PC_RESET    = 32'h1c00_0000;
    localparam inst_t INST_NOP    = 32'h0340_0000;  // andi r0, r0, 0
    localparam inst_t INST_IBAR   = 32'h3872_8000;  // ibar 0
    localparam inst_t ROM_PATTERN = 32'h2a00_0000;  // top byte keeps clear of nop and ibar

    // rom content per word index, shared by the rom and the stream model
    function automatic inst_t rom_word(input int unsigned idx);
        if (idx % 23 == 17) begin
            return INST_IBAR;
        end
        return inst_t'(idx) ^ ROM_PATTERN;
    endfunction

endpackage

/* src/pc_gen.sv */
`timescale 1ns/1ps

module pc_gen (
    input  logic            clk,
    input  logic            rstn,
    input  logic            flush,
    input  fetch_pkg::pc_t  flush_pc,
    input  logic            refetch,
    input  fetch_pkg::pc_t  refetch_pc,
    input  logic            stage_ready,
    output logic            req_valid,
    output fetch_pkg::pc_t  req_pc
);
    import fetch_pkg::*;

    logic run;  // low in reset, keeps the first cycle quiet

    // stage_ready already folds in buffer space and the ibar waits
    assign req_valid = run && stage_ready;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            run    <= 1'b0;
            req_pc <= PC_RESET;
        end else begin
            run <= 1'b1;
            if (flush) begin
                req_pc <= flush_pc;           // flush beats refetch
            end else if (refetch) begin
                req_pc <= refetch_pc;         // resume after the ibar
            end else if (req_valid) begin
                req_pc <= req_pc + 32'd8;     // next pair
            end
        end
    end

endmodule

/* src/fetch_rom.sv */
`timescale 1ns/1ps

module fetch_rom #(
    parameter int ROM_WORDS = 256
) (
    input  logic              clk,
    input  logic              rstn,
    input  logic              flush,
    input  logic              req_valid,
    input  fetch_pkg::pc_t    req_pc,
    output logic              rsp_valid,
    output fetch_pkg::pc_t    rsp_pc,
    output fetch_pkg::inst_t  rsp_inst0,
    output fetch_pkg::inst_t  rsp_inst1,
    output logic              icache_idle
);
    import fetch_pkg::*;

    localparam int AW = $clog2(ROM_WORDS);

    inst_t          mem [ROM_WORDS];
    logic [29:0]    word_idx;
    logic [AW-1:0]  addr0;
    logic [AW-1:0]  addr1;

    initial begin
        for (int i = 0; i < ROM_WORDS; i++) begin
            mem[i] = rom_word(i);
        end
    end

    // both words of the pair, wrapping at the rom depth
    assign word_idx = req_pc[31:2];
    assign addr0    = AW'(word_idx % 30'(ROM_WORDS));
    assign addr1    = AW'((word_idx + 30'd1) % 30'(ROM_WORDS));

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            rsp_valid <= 1'b0;
        end else begin
            rsp_valid <= req_valid && !flush;  // flush drops the request of this cycle
        end
    end

    always_ff @(posedge clk) begin
        if (req_valid) begin
            rsp_pc    <= req_pc;
            rsp_inst0 <= mem[addr0];
            rsp_inst1 <= mem[addr1];
        end
    end

    // nothing accepted and nothing coming back
    assign icache_idle = !req_valid && !rsp_valid;

endmodule

/* src/ibar_predecode.sv */
`timescale 1ns/1ps

module ibar_predecode (
    input  logic                   rsp_valid,
    input  fetch_pkg::inst_t       rsp_inst0,
    input  fetch_pkg::inst_t       rsp_inst1,
    output fetch_pkg::ibar_flag_t  ibar_flag
);
    import fetch_pkg::*;

    logic hit0;
    logic hit1;

    assign hit0 = (rsp_inst0 == INST_IBAR);
    assign hit1 = (rsp_inst1 == INST_IBAR);

    // stale words on the bus must not start a barrier
    assign ibar_flag = {hit1, hit0} & {2{rsp_valid}};

endmodule

/* src/if1_fifo_stage.sv */
`timescale 1ns/1ps

module if1_fifo_stage (
    input  logic                   clk,
    input  logic                   rstn,
    input  logic                   flush,
    input  logic                   rsp_valid,
    input  fetch_pkg::pc_t         rsp_pc,
    input  fetch_pkg::inst_t       rsp_inst0,
    input  fetch_pkg::inst_t       rsp_inst1,
    input  fetch_pkg::ibar_flag_t  ibar_flag,
    input  logic                   ibar_retire,
    input  logic                   icache_idle,
    input  logic                   dcache_idle,
    input  logic                   buf_full,
    output logic                   stage_ready,
    output logic                   refetch,
    output fetch_pkg::pc_t         refetch_pc,
    output logic                   push,
    output fetch_pkg::pc_t         push_pc,
    output fetch_pkg::inst_t       push_inst0,
    output fetch_pkg::inst_t       push_inst1
);
    import fetch_pkg::*;

    ibar_state_t state;
    ibar_state_t state_nxt;
    logic        cache_idle;
    logic        fetch_ok;     // refetched pair is back
    logic        accept;
    logic        reg_free;
    logic        pair_valid;
    logic        skid_valid;   // catches the one response in flight under back-pressure
    pc_t         skid_pc;
    inst_t       skid_inst0;
    inst_t       skid_inst1;

    assign cache_idle  = icache_idle && dcache_idle;
    assign fetch_ok    = state == IBAR_WAIT_FETCH && rsp_valid && rsp_pc == refetch_pc;
    assign accept      = (state == IBAR_IDLE && rsp_valid) || fetch_ok;
    assign push        = pair_valid && !buf_full;   // held pairs were all taken in idle
    assign reg_free    = !pair_valid || push;
    assign stage_ready = !buf_full && (state == IBAR_IDLE || state == IBAR_WAIT_FETCH);
    assign refetch     = state == IBAR_WAIT_CACHE && cache_idle;

    always_comb begin
        case (state)
            IBAR_IDLE:       state_nxt = |ibar_flag ? IBAR_WAIT_EX : IBAR_IDLE;
            IBAR_WAIT_EX:    state_nxt = ibar_retire ? IBAR_WAIT_CACHE : IBAR_WAIT_EX;
            IBAR_WAIT_CACHE: state_nxt = cache_idle ? IBAR_WAIT_FETCH : IBAR_WAIT_CACHE;
            IBAR_WAIT_FETCH: begin
                if (!fetch_ok) begin
                    state_nxt = IBAR_WAIT_FETCH;
                end else begin
                    state_nxt = |ibar_flag ? IBAR_WAIT_EX : IBAR_IDLE;  // back to back ibar
                end
            end
            default:         state_nxt = IBAR_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state      <= IBAR_IDLE;
            refetch_pc <= PC_RESET;
            pair_valid <= 1'b0;
            skid_valid <= 1'b0;
        end else if (flush) begin
            state      <= IBAR_IDLE;
            pair_valid <= 1'b0;
            skid_valid <= 1'b0;
        end else begin
            state <= state_nxt;
            if (accept && |ibar_flag) begin
                refetch_pc <= ibar_flag[0] ? rsp_pc + 32'd4 : rsp_pc + 32'd8;
            end
            if (reg_free) begin
                pair_valid <= skid_valid || accept;
                skid_valid <= skid_valid && accept;
            end else begin
                skid_valid <= skid_valid || accept;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (flush || (reg_free && !skid_valid && !accept)) begin
            push_pc    <= PC_RESET;   // empty slot shows a nop pair
            push_inst0 <= INST_NOP;
            push_inst1 <= INST_NOP;
        end else if (reg_free && skid_valid) begin
            push_pc    <= skid_pc;
            push_inst0 <= skid_inst0;
            push_inst1 <= skid_inst1;
        end else if (reg_free) begin
            push_pc    <= rsp_pc;
            push_inst0 <= rsp_inst0;
            push_inst1 <= rsp_inst1;
        end
        if (accept && (skid_valid || !reg_free)) begin
            skid_pc    <= rsp_pc;
            skid_inst0 <= rsp_inst0;
            skid_inst1 <= rsp_inst1;
        end
    end

    a_state_legal: assert property (@(posedge clk) disable iff (!rstn)
        state inside {IBAR_IDLE, IBAR_WAIT_EX, IBAR_WAIT_CACHE, IBAR_WAIT_FETCH})
        else $error("ibar state out of range");

    // the cache wait is only reached through the execute wait
    a_refetch_wait: assert property (@(posedge clk) disable iff (!rstn)
        refetch |-> state == IBAR_WAIT_CACHE && $past(state) != IBAR_IDLE)
        else $error("refetch outside the cache wait");

endmodule

/* src/fetch_buffer.sv */
`timescale 1ns/1ps

module fetch_buffer #(
    parameter int BUF_DEPTH = 8
) (
    input  logic              clk,
    input  logic              rstn,
    input  logic              flush,
    input  logic              push,
    input  fetch_pkg::pc_t    push_pc,
    input  fetch_pkg::inst_t  push_inst0,
    input  fetch_pkg::inst_t  push_inst1,
    input  logic              pop,
    output logic              buf_full,
    output logic              out_valid,
    output fetch_pkg::pc_t    out_pc,
    output fetch_pkg::inst_t  out_inst0,
    output fetch_pkg::inst_t  out_inst1
);
    import fetch_pkg::*;

    localparam int PW = $clog2(BUF_DEPTH);

    pc_t         pc_mem    [BUF_DEPTH];
    inst_t       inst0_mem [BUF_DEPTH];
    inst_t       inst1_mem [BUF_DEPTH];
    logic [PW-1:0] rd_ptr;
    logic [PW-1:0] wr_ptr;
    logic [PW:0]   count;
    logic        wr_en;
    logic        rd_en;

    assign buf_full  = count == (PW + 1)'(BUF_DEPTH);
    assign out_valid = count != '0;
    assign wr_en     = push && !buf_full;
    assign rd_en     = pop && out_valid;

    assign out_pc    = pc_mem[rd_ptr];
    assign out_inst0 = inst0_mem[rd_ptr];
    assign out_inst1 = inst1_mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            pc_mem[wr_ptr]    <= push_pc;
            inst0_mem[wr_ptr] <= push_inst0;
            inst1_mem[wr_ptr] <= push_inst1;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else if (flush) begin
            rd_ptr <= '0;   // drop everything queued
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) wr_ptr <= wr_ptr + 1'b1;   // depth is a power of two
            if (rd_en) rd_ptr <= rd_ptr + 1'b1;
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // the stage has to stall itself, a push into a full queue is lost
    a_no_push_full: assert property (@(posedge clk) disable iff (!rstn)
        push |-> !buf_full)
        else $error("push while buffer full");

    a_no_pop_empty: assert property (@(posedge clk) disable iff (!rstn)
        pop && !out_valid && !flush |=> $stable(rd_ptr))
        else $error("pop accepted on empty buffer");

endmodule

/* src/fetch_frontend_top.sv */
`timescale 1ns/1ps

module fetch_frontend_top #(
    parameter int ROM_WORDS = 256,
    parameter int BUF_DEPTH = 8
) (
    input  logic              clk,
    input  logic              rstn,
    input  logic              flush,
    input  fetch_pkg::pc_t    flush_pc,
    input  logic              ibar_retire,  // barrier done in execute
    input  logic              dcache_idle,
    input  logic              pop,
    output logic              out_valid,
    output fetch_pkg::pc_t    out_pc,
    output fetch_pkg::inst_t  out_inst0,
    output fetch_pkg::inst_t  out_inst1
);
    import fetch_pkg::*;

    logic       req_valid;
    pc_t        req_pc;
    logic       rsp_valid;
    pc_t        rsp_pc;
    inst_t      rsp_inst0;
    inst_t      rsp_inst1;
    logic       icache_idle;
    ibar_flag_t ibar_flag;
    logic       stage_ready;
    logic       refetch;
    pc_t        refetch_pc;
    logic       push;
    pc_t        push_pc;
    inst_t      push_inst0;
    inst_t      push_inst1;
    logic       buf_full;

    pc_gen u_pc_gen (
        .clk, .rstn, .flush, .flush_pc, .refetch, .refetch_pc,
        .stage_ready, .req_valid, .req_pc
    );

    fetch_rom #(.ROM_WORDS(ROM_WORDS)) u_fetch_rom (
        .clk, .rstn, .flush, .req_valid, .req_pc,
        .rsp_valid, .rsp_pc, .rsp_inst0, .rsp_inst1, .icache_idle
    );

    ibar_predecode u_ibar_predecode (
        .rsp_valid, .rsp_inst0, .rsp_inst1, .ibar_flag
    );

    if1_fifo_stage u_if1_fifo_stage (
        .clk, .rstn, .flush, .rsp_valid, .rsp_pc, .rsp_inst0, .rsp_inst1,
        .ibar_flag, .ibar_retire, .icache_idle, .dcache_idle, .buf_full,
        .stage_ready, .refetch, .refetch_pc, .push, .push_pc, .push_inst0, .push_inst1
    );

    fetch_buffer #(.BUF_DEPTH(BUF_DEPTH)) u_fetch_buffer (
        .clk, .rstn, .flush, .push, .push_pc, .push_inst0, .push_inst1,
        .pop, .buf_full, .out_valid, .out_pc, .out_inst0, .out_inst1
    );

endmodule

/* bench/tb_fetch_frontend.sv */
`timescale 1ns/1ps

module tb_fetch_frontend;
    import fetch_pkg::*;

    localparam int ROM_WORDS      = 256;
    localparam int BUF_DEPTH      = 8;
    localparam int RESET_CYCLES   = 5;
    localparam int NUM_PAIRS      = 800;
    localparam int PLAN_CYCLES    = NUM_PAIRS * 3 + RESET_CYCLES;  // about 3 cycles per pair
    localparam int TIMEOUT_CYCLES = 4 * PLAN_CYCLES;

    logic  clk;
    logic  rstn;
    logic  flush;
    pc_t   flush_pc;
    logic  ibar_retire;
    logic  dcache_idle;
    logic  pop;
    logic  out_valid;
    pc_t   out_pc;
    inst_t out_inst0;
    inst_t out_inst1;

    pc_t   model_pc;       // pc of the next pair the back end should see
    logic  ibar_wait;      // ibar pair popped and its successor not yet
    logic  retire_seen;
    logic  dc_seen;
    logic  retire_arm;
    logic  held;
    pc_t   held_pc;
    inst_t held_inst0;
    inst_t held_inst1;
    logic  seen_first;
    int    retire_cnt;
    int    hold_cnt;
    int    pairs_checked;
    int    ibars_seen;
    int    flushes_done;
    int    holds_done;
    int    next_flush_at;
    int    cycle_cnt = 0;

    fetch_frontend_top #(.ROM_WORDS(ROM_WORDS), .BUF_DEPTH(BUF_DEPTH)) uut (
        .clk, .rstn, .flush, .flush_pc, .ibar_retire, .dcache_idle, .pop,
        .out_valid, .out_pc, .out_inst0, .out_inst1
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic fail_run();
        $display(">>> FAIL");
        $fatal(1);
    endtask

    task automatic check_pc(input pc_t got, input pc_t exp, input string what);
        if (got !== exp) begin
            $display("Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
            fail_run();
        end
    endtask

    task automatic check_inst(input inst_t got, input inst_t exp, input string what);
        if (got !== exp) begin
            $display("Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
            fail_run();
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("Error at %0t ns: %s is %b, expected %b", $time, what, got, exp);
            fail_run();
        end
    endtask

    // expected word of a pair with the rom wrapping at its depth
    function automatic inst_t model_word(input pc_t pc, input int unsigned slot);
        int unsigned idx;
        idx = (pc[31:2] + slot) % ROM_WORDS;
        return rom_word(idx);
    endfunction

    // called just after the rising edge where all dut inputs change
    task automatic drive_inputs();
        if (pairs_checked >= next_flush_at) begin
            flush         <= 1'b1;
            flush_pc      <= $urandom & 32'hffff_fffc;  // any word aligned pc
            next_flush_at = pairs_checked + 150 + int'($urandom % 100);
            flushes_done++;
        end else begin
            flush <= 1'b0;
        end
        if (retire_arm) begin
            retire_cnt = 1 + int'($urandom % 6);   // execute takes a while
            retire_arm = 1'b0;
        end
        ibar_retire <= (retire_cnt == 1);
        if (retire_cnt > 0)
            retire_cnt--;
        if (hold_cnt > 0) begin
            pop <= 1'b0;
            hold_cnt--;
        end else if ($urandom % 80 == 0) begin
            hold_cnt = 10 + int'($urandom % 10);   // long enough to fill the buffer
            holds_done++;
            pop <= 1'b0;
        end else begin
            pop <= ($urandom % 100) < 70;
        end
        dcache_idle <= ($urandom % 4) != 0;
    endtask

    // called at the falling edge to see what the dut samples next
    task automatic check_outputs();
        inst_t exp0;
        inst_t exp1;
        if (retire_seen && dcache_idle)
            dc_seen = 1'b1;
        if (ibar_retire)
            retire_seen = 1'b1;
        if (held) begin
            check_flag(out_valid, 1'b1, "out_valid while pop held");
            check_pc(out_pc, held_pc, "head pc while pop held");
            check_inst(out_inst0, held_inst0, "head slot 0 while pop held");
            check_inst(out_inst1, held_inst1, "head slot 1 while pop held");
        end
        if (!seen_first && out_valid) begin
            seen_first = 1'b1;
            check_pc(out_pc, PC_RESET, "first pc after reset");
        end
        exp0 = model_word(model_pc, 0);
        exp1 = model_word(model_pc, 1);
        if (flush) begin
            model_pc   = flush_pc;  // stream restarts at the flush pc
            ibar_wait  = 1'b0;
            retire_arm = 1'b0;
            retire_cnt = 0;
        end else if (pop && out_valid) begin
            check_pc(out_pc, model_pc, "popped pc");
            check_inst(out_inst0, exp0, "popped slot 0");
            check_inst(out_inst1, exp1, "popped slot 1");
            if (ibar_wait) begin
                if (!(retire_seen && dc_seen)) begin
                    $display("pair after an ibar popped at %0t ns before retire and idle caches",
                             $time);
                    fail_run();
                end
                ibar_wait = 1'b0;
            end
            if (exp0 == INST_IBAR || exp1 == INST_IBAR) begin
                ibar_wait    = 1'b1;
                retire_seen  = 1'b0;
                dc_seen      = 1'b0;
                retire_arm   = 1'b1;
                ibars_seen++;
            end
            model_pc = (exp0 == INST_IBAR) ? model_pc + 32'd4 : model_pc + 32'd8;
            pairs_checked++;
        end
        held       = out_valid && !pop && !flush;
        held_pc    = out_pc;
        held_inst0 = out_inst0;
        held_inst1 = out_inst1;
    endtask

    initial begin
        void'($urandom(66));
        rstn          = 1'b0;
        flush         = 1'b0;
        flush_pc      = PC_RESET;
        ibar_retire   = 1'b0;
        dcache_idle   = 1'b1;
        pop           = 1'b0;
        model_pc      = PC_RESET;
        ibar_wait     = 1'b0;
        retire_seen   = 1'b0;
        dc_seen       = 1'b0;
        retire_arm    = 1'b0;
        held          = 1'b0;
        seen_first    = 1'b0;
        retire_cnt    = 0;
        hold_cnt      = 0;
        pairs_checked = 0;
        ibars_seen    = 0;
        flushes_done  = 0;
        holds_done    = 0;
        next_flush_at = 100 + int'($urandom % 100);
        repeat (RESET_CYCLES) @(posedge clk);
        rstn <= 1'b1;
        @(negedge clk);
        check_flag(out_valid, 1'b0, "out_valid after reset");
        while (pairs_checked < NUM_PAIRS) begin
            @(posedge clk);
            drive_inputs();
            @(negedge clk);
            check_outputs();
        end
        if (flushes_done > 0 && ibars_seen > 0 && holds_done > 0) begin
            $display(">>> PASS");
            $finish;
        end else begin
            $display("run ended without covering flush, ibar and pop stall");
            fail_run();
        end
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles with %0d of %0d pairs checked",
                     cycle_cnt, pairs_checked, NUM_PAIRS);
            fail_run();
        end
    end

endmodule

/* sim.f */
src/fetch_pkg.sv
src/pc_gen.sv
src/fetch_rom.sv
src/ibar_predecode.sv
src/if1_fifo_stage.sv
src/fetch_buffer.sv
src/fetch_frontend_top.sv
bench/tb_fetch_frontend.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       ?= tb_fetch_frontend
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := >>> PASS

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

sim: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q -- "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
